// File: Bender.yml
package:
  name: rename_dispatch

sources:
  - hw/rename_pkg.sv
  - hw/fifo.sv
  - hw/free_list.sv
  - hw/rename_table.sv
  - hw/rob_alloc.sv
  - hw/dispatch_ctrl.sv
  - hw/dispatcher.sv
  - hw/rename_dispatch.sv
  - target: test
    files:
      - test/tb_rename_dispatch.sv

// File: compile.f
hw/rename_pkg.sv
hw/fifo.sv
hw/free_list.sv
hw/rename_table.sv
hw/rob_alloc.sv
hw/dispatch_ctrl.sv
hw/dispatcher.sv
hw/rename_dispatch.sv
test/tb_rename_dispatch.sv

// File: hw/dispatch_ctrl.sv
// Dispatch FSM, fires one instruction per cycle and serializes stores until commit
`timescale 1ns/1ps

module dispatch_ctrl
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_valid,
    input  logic    inst_rd_zero,
    input  logic    inst_is_store,
    input  logic    out_ready,
    input  logic    rob_full,
    input  logic    free_empty,
    input  commit_t commit,
    output logic    fire
);

    typedef enum logic {
        st_run,
        st_store_wait
    } state_t;

    state_t state;
    state_t state_next;

    // rd x0 takes no register, so an empty free list does not stall it
    assign fire = inst_valid && out_ready && !rob_full
                  && (!free_empty || inst_rd_zero)
                  && (state == st_run);

    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                // Hold everything behind a store
                if (fire && inst_is_store) begin
                    state_next = st_store_wait;
                end
            end
            st_store_wait: begin
                // Only one store is ever in flight
                if (commit.valid && commit.is_store) begin
                    state_next = st_run;
                end
            end
            default: state_next = st_run;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: hw/dispatcher.sv
// Combinational builder of the dispatch entry from the queue head and the rename lookups
`timescale 1ns/1ps

module dispatcher
    import rename_pkg::*;
(
    input  inst_t                inst,
    input  logic [preg_w-1:0]    prs1,
    input  logic [preg_w-1:0]    prs2,
    input  logic [preg_w-1:0]    old_prd,
    input  logic [preg_w-1:0]    free_preg,
    input  logic                 rs1_busy,
    input  logic                 rs2_busy,
    input  logic [rob_id_w-1:0]  rob_id,
    output dispatch_entry_t      entry,
    output logic                 rd_zero
);

    // x0 never renames
    assign rd_zero = (inst.rd == '0);

    always_comb begin
        // Architectural fields pass through for the ROB
        entry.pc = inst.pc;
        entry.rs1 = inst.rs1;
        entry.rs2 = inst.rs2;
        entry.rd = inst.rd;
        entry.is_store = inst.is_store;

        // Sources use the current mappings
        entry.prs1 = prs1;
        entry.prs2 = prs2;

        // Unused operands never hold up issue
        // x0 sits in physical register 0 which is never busy
        entry.rs1_ready = !inst.uses_rs1 || !rs1_busy;
        entry.rs2_ready = !inst.uses_rs2 || !rs2_busy;

        // Destination takes the free-list head unless it is x0
        if (rd_zero) begin
            entry.prd = '0;
            entry.has_rd = 1'b0;
        end else begin
            entry.prd = free_preg;
            entry.has_rd = 1'b1;
        end

        // Previous mapping goes along so commit can free it
        entry.old_prd = old_prd;

        entry.rob_id = rob_id;
    end

endmodule

// File: hw/fifo.sv
// Circular queue with valid/ready on both sides and a payload type chosen per instance
`timescale 1ns/1ps

module fifo #(
    parameter type payload_t = logic,
    parameter int depth = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    // Payload storage
    payload_t mem [depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic push;
    logic pop;

    // Head shows combinationally
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    // When full, a pop this cycle frees the slot for a push
    assign in_ready = (count < cnt_w'(depth)) || out_ready;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/free_list.sv
// Circular list of free physical registers, loaded with 32 to 63 at reset and refilled at commit
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    output logic [preg_w-1:0] preg,
    output logic              empty,
    input  logic              push,
    input  logic [preg_w-1:0] push_preg
);

    // One slot per register that can be free at a time
    logic [preg_w-1:0] slots [free_regs];

    logic [free_ptr_w-1:0] head;
    logic [free_ptr_w-1:0] tail;
    logic [free_ptr_w:0] count;

    assign preg = slots[head];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Registers above the architectural range start free, in order
            for (int i = 0; i < free_regs; i++) begin
                slots[i] <= preg_w'(arch_regs + i);
            end
            head <= '0;
            // List is full, so the tail sits on the head
            tail <= '0;
            count <= (free_ptr_w + 1)'(free_regs);
        end else begin
            if (push) begin
                slots[tail] <= push_preg;
                tail <= tail + 1'b1;
            end
            // Pointers wrap naturally, the list size is a power of two
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/rename_dispatch.sv
// Rename and dispatch top level, between the decoder and the reservation station and ROB
`timescale 1ns/1ps

module rename_dispatch
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  inst_t           in_data,
    output logic            in_ready,
    output logic            out_valid,
    output dispatch_entry_t out_data,
    input  logic            out_ready,
    input  commit_t         commit,
    input  wb_t             wb
);

    // Instruction queue head
    logic            iq_valid;
    inst_t           iq_head;

    // Rename lookups
    logic [preg_w-1:0] prs1;
    logic [preg_w-1:0] prs2;
    logic [preg_w-1:0] old_prd;
    logic            rs1_busy;
    logic            rs2_busy;
    logic [preg_w-1:0] free_preg;
    logic            free_empty;

    // Dispatch control
    logic [rob_id_w-1:0] rob_id;
    logic            rob_full;
    logic            oq_ready;
    logic            rd_zero;
    logic            fire;
    logic            rename_en;
    dispatch_entry_t entry;

    // Only a real destination takes a register and updates the table
    assign rename_en = fire && !rd_zero;

    fifo #(
        .payload_t(inst_t),
        .depth    (inst_q_depth)
    ) i_inst_q (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .out_valid(iq_valid),
        .out_data (iq_head),
        .out_ready(fire)
    );

    rename_table i_rename_table (
        .clk     (clk),
        .rst     (rst),
        .rs1     (iq_head.rs1),
        .rs2     (iq_head.rs2),
        .rd      (iq_head.rd),
        .prs1    (prs1),
        .prs2    (prs2),
        .old_prd (old_prd),
        .rs1_busy(rs1_busy),
        .rs2_busy(rs2_busy),
        .wr_en   (rename_en),
        .wr_preg (free_preg),
        .wb      (wb)
    );

    // Registers freed at commit return to the tail
    free_list i_free_list (
        .clk      (clk),
        .rst      (rst),
        .pop      (rename_en),
        .preg     (free_preg),
        .empty    (free_empty),
        .push     (commit.free_valid),
        .push_preg(commit.old_prd)
    );

    rob_alloc i_rob_alloc (
        .clk        (clk),
        .rst        (rst),
        .alloc      (fire),
        .release_one(commit.valid),
        .rob_id     (rob_id),
        .full       (rob_full)
    );

    dispatch_ctrl i_dispatch_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (iq_valid),
        .inst_rd_zero (rd_zero),
        .inst_is_store(iq_head.is_store),
        .out_ready    (oq_ready),
        .rob_full     (rob_full),
        .free_empty   (free_empty),
        .commit       (commit),
        .fire         (fire)
    );

    dispatcher i_dispatcher (
        .inst     (iq_head),
        .prs1     (prs1),
        .prs2     (prs2),
        .old_prd  (old_prd),
        .free_preg(free_preg),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .rob_id   (rob_id),
        .entry    (entry),
        .rd_zero  (rd_zero)
    );

    // Entries wait here for the reservation station and ROB
    fifo #(
        .payload_t(dispatch_entry_t),
        .depth    (out_q_depth)
    ) i_out_q (
        .clk      (clk),
        .rst      (rst),
        .in_valid (fire),
        .in_data  (entry),
        .in_ready (oq_ready),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_ready(out_ready)
    );

endmodule

// File: hw/rename_pkg.sv
// Widths, depths and structs shared by the rename and dispatch RTL and its testbench
package rename_pkg;

    // Register file sizes
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int areg_w = 5;
    localparam int preg_w = 6;

    // Registers not mapped after reset start out in the free list
    localparam int free_regs = phys_regs - arch_regs;
    localparam int free_ptr_w = $clog2(free_regs);

    // Reorder buffer
    localparam int rob_depth = 8;
    localparam int rob_id_w = 3;

    // Queue depths
    localparam int inst_q_depth = 4;
    localparam int out_q_depth = 2;

    // Decoded instruction from the front end
    typedef struct packed {
        logic [31:0] pc;
        logic [areg_w-1:0] rs1;
        logic [areg_w-1:0] rs2;
        logic [areg_w-1:0] rd;
        logic uses_rs1;
        logic uses_rs2;
        logic is_store;
    } inst_t;

    // Renamed entry for the reservation station and ROB
    typedef struct packed {
        logic [31:0] pc;
        logic [areg_w-1:0] rs1;
        logic [areg_w-1:0] rs2;
        logic [areg_w-1:0] rd;
        logic [preg_w-1:0] prs1;
        logic [preg_w-1:0] prs2;
        logic [preg_w-1:0] prd;
        // Mapping of rd before this entry, freed when it commits
        logic [preg_w-1:0] old_prd;
        logic rs1_ready;
        logic rs2_ready;
        logic has_rd;
        logic is_store;
        logic [rob_id_w-1:0] rob_id;
    } dispatch_entry_t;

    // Commit report from the ROB, one cycle per retired entry
    typedef struct packed {
        logic valid;
        logic is_store;
        logic free_valid;
        logic [preg_w-1:0] old_prd;
    } commit_t;

    // Writeback report, clears the busy bit of preg
    typedef struct packed {
        logic valid;
        logic [preg_w-1:0] preg;
    } wb_t;

endpackage

// File: hw/rename_table.sv
// Register alias table and busy bits, read combinationally by the dispatcher each cycle
`timescale 1ns/1ps

module rename_table
    import rename_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [areg_w-1:0] rs1,
    input  logic [areg_w-1:0] rs2,
    input  logic [areg_w-1:0] rd,
    output logic [preg_w-1:0] prs1,
    output logic [preg_w-1:0] prs2,
    output logic [preg_w-1:0] old_prd,
    output logic              rs1_busy,
    output logic              rs2_busy,
    input  logic              wr_en,
    input  logic [preg_w-1:0] wr_preg,
    input  wb_t               wb
);

    // Current mapping of each architectural register
    logic [preg_w-1:0] map [arch_regs];
    // One bit per physical register awaiting writeback
    logic [phys_regs-1:0] busy;

    assign prs1 = map[rs1];
    assign prs2 = map[rs2];
    assign old_prd = map[rd];

    // Writeback in the same cycle counts as already done
    assign rs1_busy = busy[prs1] && !(wb.valid && (wb.preg == prs1));
    assign rs2_busy = busy[prs2] && !(wb.valid && (wb.preg == prs2));

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, nothing in flight
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= preg_w'(i);
            end
            busy <= '0;
        end else begin
            if (wb.valid) begin
                busy[wb.preg] <= 1'b0;
            end
            // A freshly allocated register is never the one written back
            if (wr_en) begin
                map[rd] <= wr_preg;
                busy[wr_preg] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/rob_alloc.sv
// ROB identifier allocator, tracks the tail and how many entries are in flight
`timescale 1ns/1ps

module rob_alloc
    import rename_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc,
    input  logic                release_one,
    output logic [rob_id_w-1:0] rob_id,
    output logic                full
);

    logic [rob_id_w-1:0] tail;
    // One extra bit so a full ROB is representable
    logic [rob_id_w:0] count;

    // Identifier for the next dispatched entry
    assign rob_id = tail;
    assign full = (count == (rob_id_w + 1)'(rob_depth));

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= (tail == rob_id_w'(rob_depth - 1)) ? '0 : tail + 1'b1;
            end
            // Allocate and retire together leave the occupancy alone
            if (alloc && !release_one) begin
                count <= count + 1'b1;
            end else if (release_one && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: test/tb_rename_dispatch.sv
// Table-driven testbench for rename_dispatch, with reference rename, commit and writeback models
`timescale 1ns/1ps

module tb_rename_dispatch
    import rename_pkg::*;
;

    localparam int clk_half = 20;
    localparam int n_rows = 42;
    // Watchdog budget in clock cycles
    localparam int timeout_cycles = n_rows * 60;

    // One table row, instruction fields plus expected operand readiness
    typedef struct packed {
        logic [areg_w-1:0] rs1;
        logic [areg_w-1:0] rs2;
        logic [areg_w-1:0] rd;
        logic uses_rs1;
        logic uses_rs2;
        logic is_store;
        // Wait until idle and write back everything before this row
        logic gap;
        logic exp_rs1_ready;
        logic exp_rs2_ready;
    } row_t;

    logic            clk;
    logic            rst;
    logic            in_valid;
    inst_t           in_data;
    logic            in_ready;
    logic            out_valid;
    dispatch_entry_t out_data;
    logic            out_ready;
    commit_t         commit;
    wb_t             wb;

    row_t rows [n_rows];
    int row_cnt;
    int recv_count;
    int errors;
    int store_release;
    bit store_pending;
    bit commit_hold;
    bit random_ready;
    int unsigned seed_val;

    // Reference model state
    logic [preg_w-1:0] ref_map [arch_regs];
    logic [preg_w-1:0] ref_free [$];
    int ref_rob;
    dispatch_entry_t commit_q [$];
    logic [preg_w-1:0] wb_pending [$];
    dispatch_entry_t retire;
    commit_t commit_pkt;

    rename_dispatch i_rename_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_ready(out_ready),
        .commit   (commit),
        .wb       (wb)
    );

    always #clk_half clk = ~clk;

    function automatic logic [31:0] row_pc(input int idx);
        return 32'h0000_1000 + 32'(idx) * 4;
    endfunction

    task automatic add_row(input int rs1, input int rs2, input int rd,
                           input bit u1, input bit u2, input bit st, input bit gap,
                           input bit r1, input bit r2);
        rows[row_cnt] = {areg_w'(rs1), areg_w'(rs2), areg_w'(rd), u1, u2, st, gap, r1, r2};
        row_cnt++;
    endtask

    task automatic build_table();
        // Basic renaming, x0 destination and sources, then a store
        add_row(1, 2, 3, 1, 1, 0, 0, 1, 1);
        add_row(3, 4, 5, 1, 1, 0, 0, 0, 1);
        add_row(5, 3, 0, 1, 1, 0, 0, 0, 0);
        add_row(0, 5, 6, 1, 1, 0, 0, 1, 0);
        add_row(3, 6, 3, 1, 0, 0, 0, 0, 1);
        add_row(3, 5, 7, 1, 1, 0, 1, 1, 1);
        add_row(7, 6, 0, 1, 1, 1, 0, 0, 1);
        add_row(1, 2, 8, 1, 1, 0, 0, 1, 1);
        add_row(8, 7, 9, 1, 1, 0, 0, 0, 0);
        add_row(9, 0, 0, 1, 1, 1, 0, 0, 1);
        add_row(9, 8, 9, 1, 1, 0, 0, 0, 0);
        // Dependent chain of nine, ROB fills after eight
        add_row(1, 0, 10, 1, 0, 0, 1, 1, 1);
        for (int k = 11; k < 19; k++) begin
            add_row(k - 1, 0, k, 1, 0, 0, 0, 0, 1);
        end
        // Mixed rows under random output back-pressure
        add_row(18, 10, 20, 1, 1, 0, 1, 1, 1);
        add_row(20, 19, 21, 1, 1, 0, 0, 0, 1);
        add_row(21, 20, 20, 1, 1, 0, 0, 0, 0);
        add_row(0, 0, 0, 1, 1, 0, 0, 1, 1);
        add_row(20, 21, 0, 1, 1, 1, 0, 0, 0);
        add_row(3, 31, 31, 1, 1, 0, 0, 1, 1);
        add_row(31, 20, 1, 1, 1, 0, 1, 1, 1);
        add_row(1, 1, 1, 1, 1, 0, 0, 0, 0);
        add_row(1, 27, 2, 1, 0, 0, 0, 0, 1);
        add_row(2, 1, 0, 1, 1, 0, 0, 0, 0);
        // Enough renames to pull recycled registers from the free list
        for (int j = 0; j < 12; j++) begin
            add_row(0, 0, 24 + (j % 6), 1, 0, 0, 0, 1, 1);
        end
    endtask

    // Offer one row and return on the edge where it transfers
    task automatic send_inst(input int idx);
        inst_t inst;
        inst.pc = row_pc(idx);
        inst.rs1 = rows[idx].rs1;
        inst.rs2 = rows[idx].rs2;
        inst.rd = rows[idx].rd;
        inst.uses_rs1 = rows[idx].uses_rs1;
        inst.uses_rs2 = rows[idx].uses_rs2;
        inst.is_store = rows[idx].is_store;
        in_valid <= 1'b1;
        in_data <= inst;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // One wb pulse per produced register
    task automatic write_back_all();
        wb_t pulse;
        pulse = '0;
        while (wb_pending.size() > 0) begin
            @(posedge clk);
            pulse.valid = 1'b1;
            pulse.preg = wb_pending.pop_front();
            wb <= pulse;
        end
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (rows[i].gap) begin
                in_valid <= 1'b0;
                // Everything sent so far must have left the DUT
                while (recv_count != i) begin
                    @(posedge clk);
                end
                write_back_all();
            end
            send_inst(i);
        end
        in_valid <= 1'b0;
    endtask

    // Compare one output entry against the reference model, in output order
    task automatic check_entry();
        dispatch_entry_t expected;
        row_t row;
        if (recv_count >= n_rows) begin
            $display("An entry came out after the last table row was already received");
            errors++;
            return;
        end
        row = rows[recv_count];
        expected = '0;
        expected.pc = row_pc(recv_count);
        expected.rs1 = row.rs1;
        expected.rs2 = row.rs2;
        expected.rd = row.rd;
        expected.prs1 = ref_map[row.rs1];
        expected.prs2 = ref_map[row.rs2];
        expected.old_prd = ref_map[row.rd];
        expected.rs1_ready = row.exp_rs1_ready;
        expected.rs2_ready = row.exp_rs2_ready;
        expected.is_store = row.is_store;
        expected.rob_id = rob_id_w'(ref_rob);
        // x0 keeps physical register 0 and takes nothing from the free list
        if (row.rd != '0) begin
            expected.has_rd = 1'b1;
            expected.prd = ref_free.pop_front();
            ref_map[row.rd] = expected.prd;
        end
        ref_rob = (ref_rob + 1) % rob_depth;
        if (store_pending) begin
            $display("Entry %0d was dispatched before the earlier store committed", recv_count);
            errors++;
        end
        if (out_data !== expected) begin
            $display("Fail out_data entry %0d got %h expected %h", recv_count, out_data, expected);
            errors++;
        end
        commit_q.push_back(expected);
        if (expected.has_rd) begin
            wb_pending.push_back(expected.prd);
        end
        if (expected.is_store) begin
            store_pending = 1'b1;
        end
        recv_count++;
    endtask

    // Output is stable at the falling edge, transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            check_entry();
        end
    end

    // Random output back-pressure when enabled
    always @(posedge clk) begin
        if (random_ready) begin
            out_ready <= (($urandom % 2) == 0);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // In-order commit after a random delay
    always @(posedge clk) begin
        commit <= '0;
        // Store counts as committed once the DUT has seen it
        if (store_release > 0) begin
            store_release--;
            if (store_release == 0) begin
                store_pending = 1'b0;
            end
        end
        if (!rst && !commit_hold && (commit_q.size() > 0) && (($urandom % 4) == 0)) begin
            retire = commit_q.pop_front();
            commit_pkt.valid = 1'b1;
            commit_pkt.is_store = retire.is_store;
            commit_pkt.free_valid = retire.has_rd;
            commit_pkt.old_prd = retire.old_prd;
            commit <= commit_pkt;
            if (retire.has_rd) begin
                ref_free.push_back(retire.old_prd);
            end
            if (retire.is_store) begin
                store_release = 2;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the outputs never completed", timeout_cycles);
        errors++;
        $display("Checked %0d entries with %0d errors", recv_count, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed_val = $urandom(32'hd87c);
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        commit = '0;
        wb = '0;
        row_cnt = 0;
        recv_count = 0;
        errors = 0;
        store_release = 0;
        store_pending = 1'b0;
        commit_hold = 1'b0;
        random_ready = 1'b0;
        ref_rob = 0;
        for (int i = 0; i < arch_regs; i++) begin
            ref_map[i] = preg_w'(i);
        end
        // Free list order after reset
        for (int i = arch_regs; i < phys_regs; i++) begin
            ref_free.push_back(preg_w'(i));
        end
        build_table();

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("Fail out_valid after reset got %h expected 0", out_valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail in_ready after reset got %h expected 1", in_ready);
            errors++;
        end
        @(posedge clk);
        apply_rows(0, 10);

        // Drain so the ROB starts empty, then hold commits
        while ((recv_count < 11) || (commit_q.size() > 0)) begin
            @(posedge clk);
        end
        commit_hold = 1'b1;
        apply_rows(11, 19);
        while (recv_count < 19) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if ((recv_count != 19) || out_valid) begin
            $display("A ninth entry came out while the ROB was full");
            errors++;
        end
        commit_hold = 1'b0;

        random_ready = 1'b1;
        apply_rows(20, n_rows - 1);
        while ((recv_count < n_rows) || (commit_q.size() > 0)) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("Checked %0d entries with %0d errors", recv_count, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
